/* fe_defines.svh */
// ========================================
// Front end constants
// Memory geometry and the six-bit opcode
// values shared by the decoder and memory
// ========================================

`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// Instruction memory geometry in words
`define FE_MEM_WORDS   256
`define FE_ADDR_W      8

// Primary opcodes held in bits 5:0 of an instruction word
`define FE_OP_BRK      6'h00
`define FE_OP_NOP      6'h01
`define FE_OP_ALU      6'h02
`define FE_OP_ALUI     6'h04
`define FE_OP_MUL      6'h0C
`define FE_OP_DIV      6'h0D
`define FE_OP_LOAD     6'h10
`define FE_OP_STORE    6'h18
`define FE_OP_BRANCH   6'h20
`define FE_OP_FENCE    6'h30
`define FE_OP_CSR      6'h31
`define FE_OP_POSTFIX  6'h3F

`endif

/* fe_pkg.sv */
// ========================================
// Front end types
// Vector types for words, addresses and
// decode fields, and the fetch FSM states
// ========================================

`include "fe_defines.svh"

package fe_pkg;

	// A full instruction or data word as stored in memory
	typedef logic [31:0] word_t;

	// Word address into the instruction memory
	typedef logic [`FE_ADDR_W-1:0] addr_t;

	// Primary opcode field
	typedef logic [5:0] opcode_t;

	// Register number for rt, ra and rb
	typedef logic [4:0] reg_t;

	// Immediate after sign extension or postfix composition
	typedef logic [31:0] imm_t;

	// Instruction length in words, one or two
	typedef logic [1:0] len_t;

	// Fetch sequencer states
	// Each instruction walks REQ0 through STEP once
	typedef enum logic [2:0] {
		IDLE,
		REQ0,
		WAIT0,
		REQ1,
		WAIT1,
		DECODE,
		STEP,
		HALT
	} fetch_state_t;

endpackage

/* fetch_unit.sv */
// ========================================
// Fetch unit
// Program counter and sequencer that reads
// each instruction pair, hands it to the
// decoder and steps by the decoded length
// ========================================

`timescale 1ns/1ns

module fetch_unit (
	input  logic          clk,
	input  logic          reset,
	input  logic          run,
	output logic          fetch_req,
	output fe_pkg::addr_t fetch_addr,
	input  logic          fetch_gnt,
	input  logic          fetch_rvalid,
	input  fe_pkg::word_t fetch_rdata,
	output logic          dec_en,
	output fe_pkg::word_t dec_word0,
	output fe_pkg::word_t dec_word1,
	output fe_pkg::addr_t dec_pc,
	input  logic          out_valid,
	input  fe_pkg::len_t  len,
	input  logic          brk,
	output logic          halted
);

	import fe_pkg::*;

	fetch_state_t state_q;
	fetch_state_t state_d;

	// Address of the instruction being fetched
	addr_t pc;
	// Second word address, wrapping at the top of memory
	addr_t pc_plus_one;
	// Address of the following instruction
	addr_t pc_next;

	// Captured instruction pair
	word_t word0_q;
	word_t word1_q;

	assign pc_plus_one = pc + addr_t'(1);
	assign pc_next     = pc + addr_t'(len);

	// ========================================
	// Sequencer
	// ========================================

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			IDLE: begin
				if (run) begin
					state_d = REQ0;
				end
			end
			REQ0: begin
				if (fetch_gnt) begin
					state_d = WAIT0;
				end
			end
			WAIT0: begin
				if (fetch_rvalid) begin
					state_d = REQ1;
				end
			end
			REQ1: begin
				if (fetch_gnt) begin
					state_d = WAIT1;
				end
			end
			WAIT1: begin
				if (fetch_rvalid) begin
					state_d = DECODE;
				end
			end
			DECODE: state_d = STEP;
			STEP: begin
				// A break ends fetch for good, anything else moves on
				if (out_valid) begin
					state_d = brk ? HALT : REQ0;
				end
			end
			HALT: state_d = HALT;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= IDLE;
			pc      <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == STEP && out_valid && !brk) begin
				pc <= pc_next;
			end
		end
	end

	// Each word is taken as it returns from the arbiter
	always_ff @(posedge clk) begin
		if (state_q == WAIT0 && fetch_rvalid) begin
			word0_q <= fetch_rdata;
		end
		if (state_q == WAIT1 && fetch_rvalid) begin
			word1_q <= fetch_rdata;
		end
	end

	// Requests are held as levels while waiting for a grant
	assign fetch_req  = (state_q == REQ0) || (state_q == REQ1);
	assign fetch_addr = (state_q == REQ1) ? pc_plus_one : pc;

	assign dec_en    = (state_q == DECODE);
	assign dec_word0 = word0_q;
	assign dec_word1 = word1_q;
	assign dec_pc    = pc;

	assign halted = (state_q == HALT);

endmodule

/* front_end.sv */
// ========================================
// Instruction front end
// Shared instruction memory, arbiter,
// fetch unit and registered decoder
// ========================================

`timescale 1ns/1ns

module front_end (
	input  logic            clk,
	input  logic            reset,
	input  logic            run,
	input  logic            load_req,
	input  logic            load_we,
	input  fe_pkg::addr_t   load_addr,
	input  fe_pkg::word_t   load_wdata,
	output logic            load_gnt,
	output logic            load_rvalid,
	output fe_pkg::word_t   load_rdata,
	output logic            out_valid,
	output fe_pkg::addr_t   out_pc,
	output fe_pkg::opcode_t opcode,
	output fe_pkg::reg_t    rt,
	output fe_pkg::reg_t    ra,
	output fe_pkg::reg_t    rb,
	output fe_pkg::imm_t    imm,
	output logic            has_imm,
	output fe_pkg::len_t    len,
	output logic            alu,
	output logic            mul,
	output logic            div,
	output logic            load,
	output logic            store,
	output logic            branch,
	output logic            backbr,
	output logic            fence,
	output logic            csr,
	output logic            brk,
	output logic            nop,
	output logic            illegal,
	output logic            halted
);

	import fe_pkg::*;

	// Fetch side of the arbiter
	logic  fetch_req;
	addr_t fetch_addr;
	logic  fetch_gnt;
	logic  fetch_rvalid;
	word_t fetch_rdata;

	// Memory port as driven by the arbiter
	logic  mem_en;
	logic  mem_we;
	addr_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;

	// Instruction pair handed to the decoder
	logic  dec_en;
	word_t dec_word0;
	word_t dec_word1;
	addr_t dec_pc;

	instr_mem i_instr_mem (
		.clk   (clk),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

	mem_arbiter i_mem_arbiter (
		.clk          (clk),
		.reset        (reset),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.fetch_gnt    (fetch_gnt),
		.fetch_rvalid (fetch_rvalid),
		.fetch_rdata  (fetch_rdata),
		.load_req     (load_req),
		.load_we      (load_we),
		.load_addr    (load_addr),
		.load_wdata   (load_wdata),
		.load_gnt     (load_gnt),
		.load_rvalid  (load_rvalid),
		.load_rdata   (load_rdata),
		.mem_en       (mem_en),
		.mem_we       (mem_we),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_rdata    (mem_rdata)
	);

	// The decoder's length and break flag close the loop back to fetch
	fetch_unit i_fetch_unit (
		.clk          (clk),
		.reset        (reset),
		.run          (run),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.fetch_gnt    (fetch_gnt),
		.fetch_rvalid (fetch_rvalid),
		.fetch_rdata  (fetch_rdata),
		.dec_en       (dec_en),
		.dec_word0    (dec_word0),
		.dec_word1    (dec_word1),
		.dec_pc       (dec_pc),
		.out_valid    (out_valid),
		.len          (len),
		.brk          (brk),
		.halted       (halted)
	);

	instr_decoder i_instr_decoder (
		.clk       (clk),
		.reset     (reset),
		.en        (dec_en),
		.word0     (dec_word0),
		.word1     (dec_word1),
		.pc        (dec_pc),
		.out_valid (out_valid),
		.out_pc    (out_pc),
		.opcode    (opcode),
		.rt        (rt),
		.ra        (ra),
		.rb        (rb),
		.imm       (imm),
		.has_imm   (has_imm),
		.len       (len),
		.alu       (alu),
		.mul       (mul),
		.div       (div),
		.load      (load),
		.store     (store),
		.branch    (branch),
		.backbr    (backbr),
		.fence     (fence),
		.csr       (csr),
		.brk       (brk),
		.nop       (nop),
		.illegal   (illegal)
	);

endmodule

/* instr_decoder.sv */
// ========================================
// Instruction decoder
// Splits an instruction and its optional
// immediate postfix into fields and class
// flags, registered when enabled
// ========================================

`timescale 1ns/1ns

`include "fe_defines.svh"

module instr_decoder (
	input  logic            clk,
	input  logic            reset,
	input  logic            en,
	input  fe_pkg::word_t   word0,
	input  fe_pkg::word_t   word1,
	input  fe_pkg::addr_t   pc,
	output logic            out_valid,
	output fe_pkg::addr_t   out_pc,
	output fe_pkg::opcode_t opcode,
	output fe_pkg::reg_t    rt,
	output fe_pkg::reg_t    ra,
	output fe_pkg::reg_t    rb,
	output fe_pkg::imm_t    imm,
	output logic            has_imm,
	output fe_pkg::len_t    len,
	output logic            alu,
	output logic            mul,
	output logic            div,
	output logic            load,
	output logic            store,
	output logic            branch,
	output logic            backbr,
	output logic            fence,
	output logic            csr,
	output logic            brk,
	output logic            nop,
	output logic            illegal
);

	import fe_pkg::*;

	opcode_t op;
	imm_t    imm_d;
	len_t    len_d;
	logic    pfx1;
	logic    has_imm_d;
	logic    alu_d;
	logic    mul_d;
	logic    div_d;
	logic    load_d;
	logic    store_d;
	logic    branch_d;
	logic    fence_d;
	logic    csr_d;
	logic    brk_d;
	logic    nop_d;
	logic    illegal_d;

	assign op   = word0[5:0];
	// The second word only counts when it carries the postfix opcode
	assign pfx1 = (word1[5:0] == `FE_OP_POSTFIX);

	// ========================================
	// Opcode classes
	// ========================================

	always_comb begin
		alu_d     = 1'b0;
		mul_d     = 1'b0;
		div_d     = 1'b0;
		load_d    = 1'b0;
		store_d   = 1'b0;
		branch_d  = 1'b0;
		fence_d   = 1'b0;
		csr_d     = 1'b0;
		brk_d     = 1'b0;
		nop_d     = 1'b0;
		illegal_d = 1'b0;
		case (op)
			`FE_OP_ALU,
			`FE_OP_ALUI:   alu_d    = 1'b1;
			`FE_OP_MUL:    mul_d    = 1'b1;
			`FE_OP_DIV:    div_d    = 1'b1;
			`FE_OP_LOAD:   load_d   = 1'b1;
			`FE_OP_STORE:  store_d  = 1'b1;
			`FE_OP_BRANCH: branch_d = 1'b1;
			`FE_OP_FENCE:  fence_d  = 1'b1;
			`FE_OP_CSR:    csr_d    = 1'b1;
			`FE_OP_BRK:    brk_d    = 1'b1;
			`FE_OP_NOP:    nop_d    = 1'b1;
			// A postfix on its own, or an unused value, does nothing
			default: begin
				illegal_d = 1'b1;
				nop_d     = 1'b1;
			end
		endcase
	end

	// Only these classes take an immediate operand
	assign has_imm_d = (op == `FE_OP_ALUI) || (op == `FE_OP_LOAD) ||
		(op == `FE_OP_STORE) || (op == `FE_OP_BRANCH);

	// A postfix supplies the upper 21 bits above the in-word field
	always_comb begin
		if (has_imm_d && pfx1) begin
			imm_d = {word1[26:6], word0[31:21]};
			len_d = 2'd2;
		end else begin
			imm_d = {{21{word0[31]}}, word0[31:21]};
			len_d = 2'd1;
		end
	end

	// ========================================
	// Output registers
	// ========================================

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= en;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			out_pc  <= pc;
			opcode  <= op;
			rt      <= word0[10:6];
			ra      <= word0[15:11];
			rb      <= word0[20:16];
			imm     <= imm_d;
			has_imm <= has_imm_d;
			len     <= len_d;
			alu     <= alu_d;
			mul     <= mul_d;
			div     <= div_d;
			load    <= load_d;
			store   <= store_d;
			branch  <= branch_d;
			// Backward when the final immediate is negative
			backbr  <= branch_d & imm_d[31];
			fence   <= fence_d;
			csr     <= csr_d;
			brk     <= brk_d;
			nop     <= nop_d;
			illegal <= illegal_d;
		end
	end

endmodule

/* instr_mem.sv */
// ========================================
// Instruction memory
// Single-port synchronous RAM, read data
// appears one cycle after the enable
// ========================================

`timescale 1ns/1ns

`include "fe_defines.svh"

module instr_mem (
	input  logic          clk,
	input  logic          en,
	input  logic          we,
	input  fe_pkg::addr_t addr,
	input  fe_pkg::word_t wdata,
	output fe_pkg::word_t rdata
);

	import fe_pkg::*;

	// Storage array, one word per address
	word_t mem [0:`FE_MEM_WORDS-1];

	// One access per cycle, shared by read and write
	// A write cycle also returns the old contents of the addressed word
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end
			rdata <= mem[addr];
		end
	end

endmodule

/* mem_arbiter.sv */
// ========================================
// Instruction memory arbiter
// Round-robin choice between fetch and the
// load port, with read data routed back
// to whichever side issued the read
// ========================================

`timescale 1ns/1ns

module mem_arbiter (
	input  logic          clk,
	input  logic          reset,
	input  logic          fetch_req,
	input  fe_pkg::addr_t fetch_addr,
	output logic          fetch_gnt,
	output logic          fetch_rvalid,
	output fe_pkg::word_t fetch_rdata,
	input  logic          load_req,
	input  logic          load_we,
	input  fe_pkg::addr_t load_addr,
	input  fe_pkg::word_t load_wdata,
	output logic          load_gnt,
	output logic          load_rvalid,
	output fe_pkg::word_t load_rdata,
	output logic          mem_en,
	output logic          mem_we,
	output fe_pkg::addr_t mem_addr,
	output fe_pkg::word_t mem_wdata,
	input  fe_pkg::word_t mem_rdata
);

	// Set when the load port received the most recent grant
	logic last_load;
	// Owner of the read that is in flight this cycle
	logic rd_fetch_q;
	logic rd_load_q;

	// ========================================
	// Grant selection
	// ========================================

	// The load port wins unless fetch also asks and load had the last turn
	assign load_gnt  = load_req & (~fetch_req | ~last_load);
	assign fetch_gnt = fetch_req & ~load_gnt;

	// The memory is driven by whichever side holds the grant
	assign mem_en    = load_gnt | fetch_gnt;
	assign mem_we    = load_gnt & load_we;
	assign mem_addr  = load_gnt ? load_addr : fetch_addr;
	assign mem_wdata = load_wdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			last_load  <= 1'b0;
			rd_fetch_q <= 1'b0;
			rd_load_q  <= 1'b0;
		end else begin
			if (mem_en) begin
				last_load <= load_gnt;
			end
			// Writes take a grant but return nothing
			rd_fetch_q <= fetch_gnt;
			rd_load_q  <= load_gnt & ~load_we;
		end
	end

	// Read data goes only to the side that owns the returning read
	assign fetch_rvalid = rd_fetch_q;
	assign load_rvalid  = rd_load_q;
	assign fetch_rdata  = rd_fetch_q ? mem_rdata : '0;
	assign load_rdata   = rd_load_q ? mem_rdata : '0;

endmodule

/* tb_front_end.sv */
// ========================================
// Front end testbench
// Directed tests for the load port, single
// word and postfix decode, branch direction
// and memory contention with fetch
// ========================================

`timescale 1ns/1ns

`include "fe_defines.svh"

module tb_front_end;

	import fe_pkg::*;

	localparam int GNT_LIMIT  = 50;
	localparam int HALT_LIMIT = 5000;
	localparam int MAX_INSTR  = 64;

	logic    clk;
	logic    reset;
	logic    run;
	logic    load_req;
	logic    load_we;
	addr_t   load_addr;
	word_t   load_wdata;
	logic    load_gnt;
	logic    load_rvalid;
	word_t   load_rdata;
	logic    out_valid;
	addr_t   out_pc;
	opcode_t opcode;
	reg_t    rt;
	reg_t    ra;
	reg_t    rb;
	imm_t    imm;
	logic    has_imm;
	len_t    len;
	logic    alu;
	logic    mul;
	logic    div;
	logic    load;
	logic    store;
	logic    branch;
	logic    backbr;
	logic    fence;
	logic    csr;
	logic    brk;
	logic    nop;
	logic    illegal;
	logic    halted;

	integer seed;
	integer errors;
	integer checks;
	integer tests_run;
	integer test_start_errors;

	// Last value written through the load port at each address
	word_t shadow [0:`FE_MEM_WORDS-1];

	// Program image, loaded from address zero
	word_t  prog [0:MAX_INSTR-1];
	integer prog_count;

	// Expected decode stream, one entry per instruction
	addr_t       exp_pc      [0:MAX_INSTR-1];
	opcode_t     exp_op      [0:MAX_INSTR-1];
	logic [14:0] exp_regs    [0:MAX_INSTR-1];
	imm_t        exp_imm     [0:MAX_INSTR-1];
	len_t        exp_len     [0:MAX_INSTR-1];
	logic        exp_has_imm [0:MAX_INSTR-1];
	logic [11:0] exp_flags   [0:MAX_INSTR-1];
	integer      exp_count;

	// Decode stream as seen on out_valid
	addr_t       obs_pc      [0:MAX_INSTR-1];
	opcode_t     obs_op      [0:MAX_INSTR-1];
	logic [14:0] obs_regs    [0:MAX_INSTR-1];
	imm_t        obs_imm     [0:MAX_INSTR-1];
	len_t        obs_len     [0:MAX_INSTR-1];
	logic        obs_has_imm [0:MAX_INSTR-1];
	logic [11:0] obs_flags   [0:MAX_INSTR-1];
	integer      obs_count;

	front_end i_front_end (
		.clk (clk), .reset (reset), .run (run),
		.load_req (load_req), .load_we (load_we), .load_addr (load_addr),
		.load_wdata (load_wdata), .load_gnt (load_gnt), .load_rvalid (load_rvalid),
		.load_rdata (load_rdata), .out_valid (out_valid), .out_pc (out_pc),
		.opcode (opcode), .rt (rt), .ra (ra), .rb (rb), .imm (imm),
		.has_imm (has_imm), .len (len), .alu (alu), .mul (mul), .div (div),
		.load (load), .store (store), .branch (branch), .backbr (backbr),
		.fence (fence), .csr (csr), .brk (brk), .nop (nop), .illegal (illegal),
		.halted (halted)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// Decoder outputs are sampled mid-cycle, well away from the clock edge
	always @(negedge clk) begin
		if (!reset && out_valid) begin
			if (obs_count < MAX_INSTR) begin
				obs_pc[obs_count]      = out_pc;
				obs_op[obs_count]      = opcode;
				obs_regs[obs_count]    = {rt, ra, rb};
				obs_imm[obs_count]     = imm;
				obs_len[obs_count]     = len;
				obs_has_imm[obs_count] = has_imm;
				obs_flags[obs_count]   = {alu, mul, div, load, store, branch, backbr,
					fence, csr, brk, nop, illegal};
			end
			obs_count = obs_count + 1;
		end
	end

	// ========================================
	// Checking and reporting
	// ========================================

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks = checks + 1;
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$finish;
	endtask

	task automatic report_test(input string name);
		$display("test %-20s %0d mismatches", name, errors - test_start_errors);
		test_start_errors = errors;
		tests_run = tests_run + 1;
	endtask

	// Class flags in the order alu mul div load store branch backbr fence csr brk nop illegal
	function automatic logic [11:0] class_flags(input opcode_t op, input logic neg);
		logic [11:0] f;
		f = '0;
		case (op)
			`FE_OP_ALU, `FE_OP_ALUI: f[11] = 1'b1;
			`FE_OP_MUL:    f[10] = 1'b1;
			`FE_OP_DIV:    f[9]  = 1'b1;
			`FE_OP_LOAD:   f[8]  = 1'b1;
			`FE_OP_STORE:  f[7]  = 1'b1;
			`FE_OP_BRANCH: begin
				f[6] = 1'b1;
				f[5] = neg;
			end
			`FE_OP_FENCE:  f[4]  = 1'b1;
			`FE_OP_CSR:    f[3]  = 1'b1;
			`FE_OP_BRK:    f[2]  = 1'b1;
			`FE_OP_NOP:    f[1]  = 1'b1;
			default: begin
				f[1] = 1'b1;
				f[0] = 1'b1;
			end
		endcase
		return f;
	endfunction

	function automatic logic takes_imm(input opcode_t op);
		return (op == `FE_OP_ALUI) || (op == `FE_OP_LOAD) ||
			(op == `FE_OP_STORE) || (op == `FE_OP_BRANCH);
	endfunction

	function automatic logic [10:0] rand_imm();
		return $random(seed);
	endfunction

	function automatic logic [20:0] rand_hi();
		return $random(seed);
	endfunction

	// ========================================
	// Bus helpers
	// ========================================

	// The load port helpers start and end 1 ns after a rising edge
	task automatic apply_reset();
		reset    = 1'b1;
		run      = 1'b0;
		load_req = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic load_write(input addr_t addr, input word_t data);
		integer cycles;
		load_req   = 1'b1;
		load_we    = 1'b1;
		load_addr  = addr;
		load_wdata = data;
		cycles     = 0;
		@(negedge clk);
		while (!load_gnt && cycles < GNT_LIMIT) begin
			@(negedge clk);
			cycles = cycles + 1;
		end
		if (!load_gnt) abort_run("load port write was never granted");
		@(posedge clk);
		#1;
		load_req     = 1'b0;
		load_we      = 1'b0;
		shadow[addr] = data;
		// A write returns no read data
		@(negedge clk);
		check(load_rvalid, 1'b0, "load_rvalid after a write");
		@(posedge clk);
		#1;
	endtask

	// Read data for a grant taken in the previous cycle
	task automatic check_read(input addr_t addr);
		check(load_rvalid, 1'b1, "load_rvalid one cycle after the grant");
		check(load_rdata, shadow[addr], $sformatf("load_rdata at address %0d", addr));
	endtask

	task automatic load_read(input addr_t addr);
		integer cycles;
		load_req  = 1'b1;
		load_we   = 1'b0;
		load_addr = addr;
		cycles    = 0;
		@(negedge clk);
		while (!load_gnt && cycles < GNT_LIMIT) begin
			@(negedge clk);
			cycles = cycles + 1;
		end
		if (!load_gnt) abort_run("load port read was never granted");
		@(posedge clk);
		#1;
		load_req = 1'b0;
		@(negedge clk);
		check_read(addr);
		@(posedge clk);
		#1;
	endtask

	// Keeps the load port requesting every cycle until fetch halts
	// The address moves on at each grant, so a read is always waiting
	task automatic stream_reads();
		integer cycles;
		integer waited;
		integer reads;
		logic   pending;
		addr_t  pending_addr;
		addr_t  addr;
		cycles       = 0;
		waited       = 0;
		reads        = 0;
		pending      = 1'b0;
		pending_addr = '0;
		addr         = addr_t'(200);
		load_req     = 1'b1;
		load_we      = 1'b0;
		load_addr    = addr;
		while (!halted && cycles < HALT_LIMIT) begin
			@(negedge clk);
			if (pending) begin
				check_read(pending_addr);
				pending = 1'b0;
			end
			if (load_gnt) begin
				// Round robin lets fetch in ahead of a waiting read at most once
				check(waited <= 1, 1'b1, "load read granted within one fetch grant");
				pending      = 1'b1;
				pending_addr = addr;
				reads        = reads + 1;
				waited       = 0;
				addr         = addr_t'(200 + reads % 8);
			end else begin
				waited = waited + 1;
				if (waited > GNT_LIMIT) abort_run("load port read was never granted");
			end
			@(posedge clk);
			#1;
			load_addr = addr;
			cycles    = cycles + 1;
		end
		if (!halted) abort_run("fetch never halted while the load port was reading");
		load_req = 1'b0;
		@(negedge clk);
		if (pending) begin
			check_read(pending_addr);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic wait_halted();
		integer cycles;
		cycles = 0;
		@(negedge clk);
		while (!halted && cycles < HALT_LIMIT) begin
			@(negedge clk);
			cycles = cycles + 1;
		end
		if (!halted) abort_run("fetch never reached the halted state");
	endtask

	// ========================================
	// Program building
	// ========================================

	task automatic start_program();
		prog_count = 0;
		exp_count  = 0;
	endtask

	task automatic expect_instr(input addr_t pc, input opcode_t op, input reg_t rt_v,
		input reg_t ra_v, input reg_t rb_v, input imm_t imm_v, input len_t len_v);
		exp_pc[exp_count]      = pc;
		exp_op[exp_count]      = op;
		exp_regs[exp_count]    = {rt_v, ra_v, rb_v};
		exp_imm[exp_count]     = imm_v;
		exp_len[exp_count]     = len_v;
		exp_has_imm[exp_count] = takes_imm(op);
		// Direction comes from the sign of the final immediate
		exp_flags[exp_count]   = class_flags(op, imm_v[31]);
		exp_count              = exp_count + 1;
	endtask

	// One-word instruction with random register fields
	task automatic emit(input opcode_t op, input logic [10:0] imm11);
		reg_t rt_v;
		reg_t ra_v;
		reg_t rb_v;
		rt_v = $random(seed);
		ra_v = $random(seed);
		rb_v = $random(seed);
		prog[prog_count] = {imm11, rb_v, ra_v, rt_v, op};
		expect_instr(addr_t'(prog_count), op, rt_v, ra_v, rb_v,
			{{21{imm11[10]}}, imm11}, 2'd1);
		prog_count = prog_count + 1;
	endtask

	// Instruction followed by a postfix carrying the upper 21 immediate bits
	task automatic emit_pfx(input opcode_t op, input logic [10:0] imm11,
		input logic [20:0] hi21);
		reg_t rt_v;
		reg_t ra_v;
		reg_t rb_v;
		logic [4:0] spare;
		rt_v  = $random(seed);
		ra_v  = $random(seed);
		rb_v  = $random(seed);
		spare = $random(seed);
		prog[prog_count]     = {imm11, rb_v, ra_v, rt_v, op};
		prog[prog_count + 1] = {spare, hi21, `FE_OP_POSTFIX};
		expect_instr(addr_t'(prog_count), op, rt_v, ra_v, rb_v, {hi21, imm11}, 2'd2);
		prog_count = prog_count + 2;
	endtask

	task automatic load_program();
		integer i;
		for (i = 0; i < prog_count; i = i + 1) begin
			load_write(addr_t'(i), prog[i]);
		end
	endtask

	task automatic compare_stream();
		integer i;
		integer n;
		check(obs_count, exp_count, "number of decoded instructions");
		n = (obs_count < exp_count) ? obs_count : exp_count;
		for (i = 0; i < n; i = i + 1) begin
			check(obs_pc[i], exp_pc[i], $sformatf("out_pc of instruction %0d", i));
			check(obs_op[i], exp_op[i], $sformatf("opcode of instruction %0d", i));
			check(obs_regs[i], exp_regs[i], $sformatf("rt ra rb of instruction %0d", i));
			check(obs_imm[i], exp_imm[i], $sformatf("imm of instruction %0d", i));
			check(obs_len[i], exp_len[i], $sformatf("len of instruction %0d", i));
			check(obs_has_imm[i], exp_has_imm[i], $sformatf("has_imm of instruction %0d", i));
			check(obs_flags[i], exp_flags[i], $sformatf("class flags of instruction %0d", i));
		end
	endtask

	// Loads the program, runs it to the break and watches for stray decodes
	task automatic run_program();
		integer seen;
		apply_reset();
		load_program();
		obs_count = 0;
		run       = 1'b1;
		wait_halted();
		seen = obs_count;
		repeat (20) @(negedge clk);
		check(obs_count, seen, "out_valid count after halt");
		@(posedge clk);
		#1;
		run = 1'b0;
		compare_stream();
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic load_readback();
		addr_t  addrs [0:15];
		word_t  data;
		integer i;
		for (i = 0; i < 16; i = i + 1) begin
			addrs[i] = $random(seed);
			data     = $random(seed);
			load_write(addrs[i], data);
		end
		for (i = 0; i < 16; i = i + 1) begin
			load_read(addrs[i]);
		end
		report_test("load_readback");
	endtask

	task automatic single_word_decode();
		start_program();
		emit(`FE_OP_NOP, rand_imm());
		emit(`FE_OP_ALU, rand_imm());
		emit(`FE_OP_ALUI, rand_imm());
		emit(`FE_OP_MUL, rand_imm());
		emit(`FE_OP_DIV, rand_imm());
		emit(`FE_OP_LOAD, rand_imm());
		emit(`FE_OP_STORE, rand_imm());
		emit(`FE_OP_BRANCH, rand_imm());
		emit(`FE_OP_FENCE, rand_imm());
		emit(`FE_OP_CSR, rand_imm());
		emit(`FE_OP_BRK, rand_imm());
		run_program();
		report_test("single_word_decode");
	endtask

	task automatic postfix_immediate();
		start_program();
		emit_pfx(`FE_OP_ALUI, rand_imm(), rand_hi());
		emit_pfx(`FE_OP_LOAD, rand_imm(), rand_hi());
		emit_pfx(`FE_OP_BRANCH, rand_imm(), rand_hi());
		// An ALU ignores the postfix, which then decodes on its own
		emit(`FE_OP_ALU, rand_imm());
		emit(`FE_OP_POSTFIX, rand_imm());
		emit(`FE_OP_BRK, rand_imm());
		run_program();
		report_test("postfix_immediate");
	endtask

	task automatic branch_and_illegal();
		start_program();
		emit(`FE_OP_BRANCH, rand_imm() | 11'h400);
		emit(`FE_OP_BRANCH, rand_imm() & 11'h3FF);
		emit_pfx(`FE_OP_BRANCH, rand_imm(), rand_hi() | 21'h100000);
		emit_pfx(`FE_OP_BRANCH, rand_imm() | 11'h400, rand_hi() & 21'h0FFFFF);
		// Two opcode values with no assigned class
		emit(6'h05, rand_imm());
		emit(6'h2A, rand_imm());
		emit(`FE_OP_BRK, rand_imm());
		run_program();
		report_test("branch_and_illegal");
	endtask

	task automatic fetch_contention();
		integer i;
		start_program();
		for (i = 0; i < 24; i = i + 1) begin
			emit(`FE_OP_NOP, rand_imm());
		end
		emit(`FE_OP_BRK, rand_imm());
		apply_reset();
		load_program();
		for (i = 0; i < 8; i = i + 1) begin
			load_write(addr_t'(200 + i), $random(seed));
		end
		obs_count = 0;
		run       = 1'b1;
		// The load port keeps reading the data area while fetch runs
		fork
			wait_halted();
			stream_reads();
		join
		@(posedge clk);
		#1;
		run = 1'b0;
		compare_stream();
		report_test("fetch_contention");
	endtask

	initial begin
		seed              = 79359;
		errors            = 0;
		checks            = 0;
		tests_run         = 0;
		test_start_errors = 0;
		obs_count         = 0;
		exp_count         = 0;
		prog_count        = 0;
		reset             = 1'b1;
		run               = 1'b0;
		load_req          = 1'b0;
		load_we           = 1'b0;
		load_addr         = '0;
		load_wdata        = '0;
		apply_reset();
		load_readback();
		single_word_decode();
		postfix_immediate();
		branch_and_illegal();
		fetch_contention();
		$display("tests run %0d, checks %0d, mismatches %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+.
fe_pkg.sv
instr_mem.sv
mem_arbiter.sv
fetch_unit.sv
instr_decoder.sv
front_end.sv
tb_front_end.sv
